// ==== pwmBusDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmBusDecode #(
	parameter logic [7:0] ID = 8'h02
)(
	input wire clk,
	input wire arstN,
	input wire pwmPkg::busAddr_t address,
	input wire we,
	input wire oe,
	input wire pwmPkg::byteSel_t byteSelect,
	input wire pwmPkg::busData_t dataWrite,
	pwmRegIf.decode regPorts [pwmPkg::deviceCount]
);
	import pwmPkg::*;

	logic peripheralEnable;
	logic [deviceFieldWidth-1:0] deviceNumber;
	logic [$bits(regIndex_t)-1:0] regField;
	logic regValid;
	logic [deviceCount-1:0] deviceSelect;

	// --------------------
	// address fields
	// --------------------
	assign peripheralEnable = (address[busAddrWidth-1:localAddrWidth] == ID);
	assign deviceNumber = address[deviceFieldLsb +: deviceFieldWidth];
	assign regField = address[regFieldLsb +: $bits(regIndex_t)];
	assign regValid = (regField <= regCompare3);  // index 7 is a hole in the map.

	// device numbers on the bus start at one.
	for (genvar i = 0; i < deviceCount; i++) begin : gSelect
		assign deviceSelect[i] = peripheralEnable && regValid &&
			(deviceNumber == deviceFieldWidth'(i + 1));

		assign regPorts[i].select = deviceSelect[i];
		assign regPorts[i].write = deviceSelect[i] & we;
		assign regPorts[i].read = deviceSelect[i] & oe;
		assign regPorts[i].regIndex = regIndex_t'(regField);
		assign regPorts[i].byteSelect = byteSelect;
		assign regPorts[i].dataWrite = dataWrite;
	end

	// --------------------
	// bus checks
	// --------------------
	assert property (@(posedge clk) disable iff (!arstN) !(we && oe))
		else $error("pwmBusDecode: write and output enable high together");

endmodule

`default_nettype wire

// ==== pwmCases.txt ====
# op id dev reg bsel data expect, all hex; read expects data at expect
# duty uses reg as output number, data as window in clocks; idle expects pwmEn
write 02 2 1 f 12345678 0
read  02 2 1 0 0 12345678
write 02 2 1 4 00ab0000 0
read  02 2 1 0 0 12ab5678
write 02 2 1 9 ff0000cd 0
read  02 2 1 0 0 ffab56cd
write 02 2 2 f abcd1234 0
read  02 2 2 0 0 00001234
write 02 2 2 2 0000ff00 0
read  02 2 2 0 0 0000ff34
write 02 2 3 2 0000ee00 0
write 02 2 3 c 12340000 0
read  02 2 3 0 0 0000ee00
read  03 1 0 0 0 ffffffff
read  02 0 0 0 0 ffffffff
read  02 5 0 0 0 ffffffff
read  02 1 7 0 0 ffffffff
write 03 1 3 f 00000055 0
write 02 5 3 f 00000055 0
write 02 1 7 f 00000055 0
read  02 1 3 0 0 00000000
write 02 4 3 f 00000001 0
write 02 4 0 f 00000001 0
write 02 1 3 f 00000003 0
write 02 1 4 f 0000000c 0
write 02 1 5 f 00000005 0
write 02 1 6 f 00000007 0
write 02 1 0 f 0000000b 0
write 02 1 1 f 00000002 0
write 02 1 2 f 00000009 0
idle  02 0 0 0 00000004 0000100b
duty  02 1 0 0 0000001e 00000009
duty  02 1 1 0 0000001e 0000001e
duty  02 1 2 0 0000001e 00000000
duty  02 1 3 0 0000001e 00000015
duty  02 4 0 0 00000008 00000008
write 02 1 0 1 00000000 0
idle  02 0 0 0 00000002 00001000
duty  02 1 3 0 0000001e 00000000

// ==== pwmController.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmController #(
	parameter logic [7:0] ID = 8'h02
)(
	input wire clk,
	input wire arstN,

	// peripheral bus.
	input wire we,
	input wire oe,
	output logic busy,
	input wire pwmPkg::busAddr_t address,
	input wire pwmPkg::byteSel_t byteSelect,
	input wire pwmPkg::busData_t dataWrite,
	output pwmPkg::busData_t dataRead,
	output logic requestOutput,

	output logic [pwmPkg::deviceCount*pwmPkg::outputsPerDevice-1:0] pwmEn,
	output logic [pwmPkg::deviceCount*pwmPkg::outputsPerDevice-1:0] pwmOut
);
	import pwmPkg::*;

	pwmRegIf regPorts [deviceCount] ();

	// --------------------
	// bus input side
	// --------------------
	pwmBusDecode #(
		.ID(ID)
	) decode (
		.clk(clk),
		.arstN(arstN),
		.address(address),
		.we(we),
		.oe(oe),
		.byteSelect(byteSelect),
		.dataWrite(dataWrite),
		.regPorts(regPorts)
	);

	// --------------------
	// pwm devices
	// --------------------
	for (genvar i = 0; i < deviceCount; i++) begin : gDevice
		pwmDevice device (
			.clk(clk),
			.arstN(arstN),
			.regPort(regPorts[i]),
			.pwmEn(pwmEn[i*outputsPerDevice +: outputsPerDevice]),
			.pwmOut(pwmOut[i*outputsPerDevice +: outputsPerDevice])
		);
	end

	// --------------------
	// bus read side
	// --------------------
	pwmReadMux readMux (
		.regPorts(regPorts),
		.dataRead(dataRead),
		.requestOutput(requestOutput)
	);

	assign busy = 1'b0;  // every access completes in its own cycle.

endmodule

`default_nettype wire

// ==== pwmDevice.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmDevice (
	input wire clk,
	input wire arstN,
	pwmRegIf.device regPort,
	output logic [pwmPkg::outputsPerDevice-1:0] pwmEn,
	output logic [pwmPkg::outputsPerDevice-1:0] pwmOut
);
	import pwmPkg::*;

	logic [outputsPerDevice-1:0] enableReg;
	logic [prescaleWidth-1:0] prescaleReg;
	logic [compareWidth-1:0] topReg;
	logic [compareWidth-1:0] compareReg [outputsPerDevice];

	logic [prescaleWidth-1:0] prescaleCount;
	logic [compareWidth-1:0] periodCount;
	logic restart;

	busData_t currentValue;
	busData_t mergedWrite;

	// --------------------
	// register access
	// --------------------
	always_comb begin
		case (regPort.regIndex)
			regEnable: currentValue = busData_t'(enableReg);
			regPrescale: currentValue = busData_t'(prescaleReg);
			regTop: currentValue = busData_t'(topReg);
			regCompare0: currentValue = busData_t'(compareReg[0]);
			regCompare1: currentValue = busData_t'(compareReg[1]);
			regCompare2: currentValue = busData_t'(compareReg[2]);
			regCompare3: currentValue = busData_t'(compareReg[3]);
			default: currentValue = '0;
		endcase
	end

	// unselected bytes keep what the register already holds.
	always_comb begin
		for (int b = 0; b < $bits(byteSel_t); b++) begin
			mergedWrite[b*8 +: 8] = regPort.byteSelect[b] ?
				regPort.dataWrite[b*8 +: 8] : currentValue[b*8 +: 8];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			enableReg <= '0;
			prescaleReg <= '0;
			topReg <= '0;
			for (int k = 0; k < outputsPerDevice; k++) begin
				compareReg[k] <= '0;
			end
		end else if (regPort.write) begin
			case (regPort.regIndex)
				regEnable: enableReg <= mergedWrite[outputsPerDevice-1:0];
				regPrescale: prescaleReg <= mergedWrite[prescaleWidth-1:0];
				regTop: topReg <= mergedWrite[compareWidth-1:0];
				regCompare0: compareReg[0] <= mergedWrite[compareWidth-1:0];
				regCompare1: compareReg[1] <= mergedWrite[compareWidth-1:0];
				regCompare2: compareReg[2] <= mergedWrite[compareWidth-1:0];
				regCompare3: compareReg[3] <= mergedWrite[compareWidth-1:0];
				default: ;
			endcase
		end
	end

	assign regPort.dataRead = currentValue;
	assign regPort.requestOutput = regPort.select & regPort.read;

	// --------------------
	// counters
	// --------------------
	// a new prescale or top value starts a fresh period.
	assign restart = regPort.write &&
		(regPort.regIndex == regPrescale || regPort.regIndex == regTop);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			prescaleCount <= '0;
			periodCount <= '0;
		end else if (restart) begin
			prescaleCount <= '0;
			periodCount <= '0;
		end else if (prescaleCount >= prescaleReg) begin
			prescaleCount <= '0;
			if (periodCount >= topReg) begin
				periodCount <= '0;
			end else begin
				periodCount <= periodCount + 1'b1;
			end
		end else begin
			prescaleCount <= prescaleCount + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pwmOut <= '0;
		end else begin
			for (int k = 0; k < outputsPerDevice; k++) begin
				pwmOut[k] <= enableReg[k] && (periodCount < compareReg[k]);
			end
		end
	end

	assign pwmEn = enableReg;

	// a restart keeps both counters inside the new limits.
	assert property (@(posedge clk) disable iff (!arstN) prescaleCount <= prescaleReg)
		else $error("pwmDevice: prescale counter beyond its limit");

	assert property (@(posedge clk) disable iff (!arstN) periodCount <= topReg)
		else $error("pwmDevice: period counter beyond its limit");

endmodule

`default_nettype wire

// ==== pwmPkg.sv ====
`default_nettype none

package pwmPkg;

	// --------------------
	// peripheral geometry
	// --------------------
	localparam int deviceCount = 4;
	localparam int outputsPerDevice = 4;
	localparam int compareWidth = 16;  // period and compare values.
	localparam int prescaleWidth = 32;

	// --------------------
	// peripheral bus
	// --------------------
	localparam int busAddrWidth = 24;
	localparam int busDataWidth = 32;
	localparam int localAddrWidth = 16;  // bits above this hold the peripheral ID.

	// local address fields.
	localparam int deviceFieldLsb = 8;
	localparam int deviceFieldWidth = 4;
	localparam int regFieldLsb = 2;

	typedef logic [busDataWidth-1:0] busData_t;
	typedef logic [busAddrWidth-1:0] busAddr_t;
	typedef logic [busDataWidth/8-1:0] byteSel_t;

	// register index within one device, taken from local address bits 4:2.
	typedef enum logic [2:0] {
		regEnable = 3'd0,
		regPrescale = 3'd1,
		regTop = 3'd2,
		regCompare0 = 3'd3,
		regCompare1 = 3'd4,
		regCompare2 = 3'd5,
		regCompare3 = 3'd6
	} regIndex_t;

	// returned on the bus when no device claims the read.
	localparam busData_t readDefault = '1;

endpackage

`default_nettype wire

// ==== pwmReadMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmReadMux (
	pwmRegIf.mux regPorts [pwmPkg::deviceCount],
	output pwmPkg::busData_t dataRead,
	output logic requestOutput
);
	import pwmPkg::*;

	busData_t deviceData [deviceCount];
	logic [deviceCount-1:0] deviceRequest;

	for (genvar i = 0; i < deviceCount; i++) begin : gGather
		assign deviceData[i] = regPorts[i].dataRead;
		assign deviceRequest[i] = regPorts[i].requestOutput;
	end

	// --------------------
	// read select
	// --------------------
	always_comb begin
		dataRead = readDefault;  // nobody answered.
		for (int i = 0; i < deviceCount; i++) begin
			if (deviceRequest[i]) begin
				dataRead = deviceData[i];
			end
		end
	end

	assign requestOutput = |deviceRequest;

	// only the addressed device may answer.
	always_comb begin
		if (!$isunknown(deviceRequest)) begin
			assert #0 ($onehot0(deviceRequest))
				else $error("pwmReadMux: several devices answered a read");
		end
	end

endmodule

`default_nettype wire

// ==== pwmRegIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pwmRegIf;
	import pwmPkg::*;

	logic select;  // address hits this device and a valid register.
	logic write;
	logic read;
	regIndex_t regIndex;
	byteSel_t byteSelect;
	busData_t dataWrite;
	busData_t dataRead;
	logic requestOutput;  // device claims the current read.

	modport decode (
		output select,
		output write,
		output read,
		output regIndex,
		output byteSelect,
		output dataWrite
	);

	modport device (
		input select,
		input write,
		input read,
		input regIndex,
		input byteSelect,
		input dataWrite,
		output dataRead,
		output requestOutput
	);

	// read-back view used by the bus read path.
	modport mux (
		input dataRead,
		input requestOutput
	);

endinterface

`default_nettype wire

// ==== runSim.sh ====
#!/bin/bash
# builds the testbench with Verilator, runs it and scans the log.
set -e
set -o pipefail
cd "$(dirname "$0")"

logFile=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tbPwmController \
	-f vlog.f \
	-o simPwmController

./obj_dir/simPwmController | tee "$logFile"

if grep -q "STATUS: FAIL" "$logFile"; then
	echo "simulation reported errors, see $logFile"
	exit 1
fi

echo "simulation finished without errors"

// ==== tbPwmChecks.svh ====
`ifndef TB_PWM_CHECKS_SVH
`define TB_PWM_CHECKS_SVH

// one counter per kind of result.
int dataErrors = 0;
int requestErrors = 0;
int dutyErrors = 0;
int outputErrors = 0;
int timeoutErrors = 0;
int fileErrors = 0;

task automatic checkData(input pwmPkg::busData_t got, input pwmPkg::busData_t expected,
		input string what);
	if (got !== expected) begin
		dataErrors++;
		$display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, expected);
	end
endtask

task automatic checkRequest(input logic got, input logic expected, input string what);
	if (got !== expected) begin
		requestErrors++;
		$display("[ERROR] %0t: %s: got %b, expected %b", $time, what, got, expected);
	end
endtask

task automatic checkDuty(input int got, input int expected, input string what);
	if (got != expected) begin
		dutyErrors++;
		$display("[ERROR] %0t: %s: %0d high cycles, expected %0d", $time, what, got, expected);
	end
endtask

task automatic checkOutputs(input logic [pwmPkg::deviceCount*pwmPkg::outputsPerDevice-1:0] got,
		input logic [pwmPkg::deviceCount*pwmPkg::outputsPerDevice-1:0] expected,
		input string what);
	if (got !== expected) begin
		outputErrors++;
		$display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, expected);
	end
endtask

`endif

// ==== tbPwmController.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbPwmController;
	import pwmPkg::*;

	localparam logic [7:0] peripheralId = 8'h02;
	localparam int outputCount = deviceCount * outputsPerDevice;
	localparam string caseFile = "pwmCases.txt";

	logic clk = 1'b0;
	logic arstN;
	logic we;
	logic oe;
	logic busy;
	busAddr_t address;
	byteSel_t byteSelect;
	busData_t dataWrite;
	busData_t dataRead;
	logic requestOutput;
	logic [outputCount-1:0] pwmEn;
	logic [outputCount-1:0] pwmOut;
	integer seed;

	`include "tbPwmChecks.svh"

	pwmController #(
		.ID(peripheralId)
	) dut (
		.clk(clk),
		.arstN(arstN),
		.we(we),
		.oe(oe),
		.busy(busy),
		.address(address),
		.byteSelect(byteSelect),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.requestOutput(requestOutput),
		.pwmEn(pwmEn),
		.pwmOut(pwmOut)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (arstN) begin
			checkRequest(busy, 1'b0, "busy");  // the bus never stalls.
		end
	end

	// --------------------
	// bus helpers
	// --------------------
	function automatic busAddr_t makeAddress(input logic [7:0] id, input logic [3:0] dev,
			input logic [2:0] regNum);
		return {id, 4'h0, dev, 3'b000, regNum, 2'b00};
	endfunction

	// true when a device register answers this address.
	function automatic logic addressHits(input logic [7:0] id, input logic [3:0] dev,
			input logic [2:0] regNum);
		return (id == peripheralId) && (dev >= 4'd1) && (dev <= 4'(deviceCount)) &&
			(regNum <= 3'd6);
	endfunction

	task automatic busWrite(input logic [7:0] id, input logic [3:0] dev, input logic [2:0] regNum,
			input byteSel_t bsel, input busData_t data);
		logic [outputCount-1:0] enBefore;
		logic [outputCount-1:0] keepMask;
		enBefore = pwmEn;
		keepMask = '1;
		if (addressHits(id, dev, regNum)) begin
			keepMask[(dev-1)*outputsPerDevice +: outputsPerDevice] = '0;
		end
		address = makeAddress(id, dev, regNum);
		byteSelect = bsel;
		dataWrite = data;
		we = 1'b1;
		@(posedge clk);
		@(negedge clk);
		we = 1'b0;
		checkOutputs(pwmEn & keepMask, enBefore & keepMask, "pwmEn of untouched devices");
	endtask

	task automatic busRead(input logic [7:0] id, input logic [3:0] dev, input logic [2:0] regNum,
			input busData_t expData);
		address = makeAddress(id, dev, regNum);
		oe = 1'b1;
		@(posedge clk);
		checkData(dataRead, expData, $sformatf("read of device %0d register %0d", dev, regNum));
		checkRequest(requestOutput, addressHits(id, dev, regNum), "read request");
		@(negedge clk);
		oe = 1'b0;
	endtask

	// random bus traffic with both enables low.
	task automatic idleCycles(input int cycles, input logic [outputCount-1:0] expEn);
		for (int i = 0; i < cycles; i++) begin
			address = busAddr_t'($random(seed));
			dataWrite = busData_t'($random(seed));
			byteSelect = byteSel_t'($random(seed));
			@(negedge clk);
		end
		checkOutputs(pwmEn, expEn, "pwmEn");
	endtask

	task automatic measureDuty(input logic [3:0] dev, input logic [2:0] k, input int period,
			input int expected);
		int index;
		int waited;
		int highCount;
		logic previous;
		logic rose;
		index = (dev - 1) * outputsPerDevice + k;
		if (expected != 0 && expected != period) begin
			rose = 1'b0;
			previous = pwmOut[index];
			waited = 0;
			while (!rose && waited < 2 * period + 8) begin
				@(negedge clk);
				waited++;
				rose = !previous && pwmOut[index];
				previous = pwmOut[index];
			end
			if (!rose) begin
				$display("timeout: output %0d of device %0d never rose within %0d cycles",
					k, dev, waited);
				timeoutErrors++;
				return;
			end
		end
		highCount = 0;
		for (int i = 0; i < period; i++) begin
			if (pwmOut[index]) begin
				highCount++;
			end
			@(negedge clk);
		end
		checkDuty(highCount, expected, $sformatf("duty of device %0d output %0d", dev, k));
	endtask

	task automatic checkResetState();
		checkOutputs(pwmOut, '0, "pwmOut after reset");
		checkOutputs(pwmEn, '0, "pwmEn after reset");
		// a valid register address must stay silent while output enable is low.
		address = makeAddress(peripheralId, 4'd1, 3'd0);
		@(negedge clk);
		checkRequest(requestOutput, 1'b0, "request with output enable low");
		checkData(dataRead, readDefault, "read data with output enable low");
		for (int d = 1; d <= deviceCount; d++) begin
			for (int r = 0; r <= int'(regCompare3); r++) begin
				busRead(peripheralId, 4'(d), 3'(r), '0);
			end
		end
	endtask

	// --------------------
	// case file driver
	// --------------------
	initial begin
		integer fd;
		int fields;
		int caseCount;
		int totalErrors;
		string line;
		string op;
		logic [7:0] id;
		logic [3:0] dev;
		logic [2:0] regNum;
		byteSel_t bsel;
		busData_t data;
		busData_t expValue;
		seed = 32'h6d0484ca;
		caseCount = 0;
		arstN = 1'b0;
		we = 1'b0;
		oe = 1'b0;
		address = '0;
		byteSelect = '0;
		dataWrite = '0;
		repeat (8) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		checkResetState();
		fd = $fopen(caseFile, "r");
		if (fd == 0) begin
			$display("could not open the case file %s", caseFile);
			fileErrors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) == 0) continue;
				if (line.len() == 0 || line.getc(0) == "#") continue;
				fields = $sscanf(line, "%s %h %h %h %h %h %h",
					op, id, dev, regNum, bsel, data, expValue);
				if (fields != 7) continue;
				caseCount++;
				case (op)
					"write": busWrite(id, dev, regNum, bsel, data);
					"read": busRead(id, dev, regNum, expValue);
					"duty": measureDuty(dev, regNum, int'(data), int'(expValue));
					"idle": idleCycles(int'(data), expValue[outputCount-1:0]);
					default: begin
						$display("unknown opcode %s in the case file", op);
						fileErrors++;
					end
				endcase
			end
			$fclose(fd);
			if (caseCount == 0) begin
				$display("the case file holds no cases");
				fileErrors++;
			end
		end
		totalErrors = dataErrors + requestErrors + dutyErrors + outputErrors +
			timeoutErrors + fileErrors;
		$display("%0d cases, errors: data %0d request %0d duty %0d outputs %0d timeout %0d file %0d",
			caseCount, dataErrors, requestErrors, dutyErrors, outputErrors,
			timeoutErrors, fileErrors);
		if (totalErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
pwmPkg.sv
pwmRegIf.sv
pwmBusDecode.sv
pwmDevice.sv
pwmReadMux.sv
pwmController.sv
tbPwmController.sv
